/* logic/fm_audio_pkg.sv */
package fm_audio_pkg;

    // One internal clock enable every six external enables
    localparam int CEN_DIV   = 6;
    localparam int NUM_SLOTS = 24;  // Operator slots per sample

    // Timer counters
    localparam int TIMER_A_W        = 10;
    localparam int TIMER_B_W        = 8;
    localparam int TIMER_B_PRESCALE = 16;  // Samples per timer B step

    // PCM input and sound output
    localparam int PCM_W      = 8;
    localparam int SND_W      = 16;
    localparam int PCM_OFFSET = 128;  // Offset-binary zero level

endpackage

/* logic/fm_chip_top.sv */
module fm_chip_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     cen,    // External clock enable
    input  logic [7:0]                               din,
    input  logic [1:0]                               addr,   // Bit 1 not decoded
    input  logic                                     cs_n,
    input  logic                                     wr_n,
    output logic [7:0]                               dout,
    output logic                                     irq_n,
    output logic signed [fm_audio_pkg::SND_W-1:0]    snd_left,
    output logic signed [fm_audio_pkg::SND_W-1:0]    snd_right,
    output logic                                     snd_sample
);
    import fm_regs_pkg::*;
    import fm_audio_pkg::*;

    logic                   write;
    logic                   busy;
    logic                   zero;   // One clock per sample
    logic [TIMER_A_W-1:0]   value_a;
    logic [TIMER_B_W-1:0]   value_b;
    logic                   load_a;
    logic                   load_b;
    logic                   irq_en_a;
    logic                   irq_en_b;
    logic                   clr_flag_a;
    logic                   clr_flag_b;
    logic                   flag_a;
    logic                   flag_b;
    logic [PCM_W-1:0]       pcm;
    logic                   pcm_en;
    logic [1:0]             rl;

    assign write = !cs_n && !wr_n;

    // Status byte
    always_comb begin
        dout              = '0;
        dout[STAT_BUSY]   = busy;
        dout[STAT_FLAG_B] = flag_b;
        dout[STAT_FLAG_A] = flag_a;
    end

    fm_mmr u_mmr (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen        ( cen        ),
        .write      ( write      ),
        .addr_sel   ( addr[0]    ),
        .din        ( din        ),
        .busy       ( busy       ),
        .zero       ( zero       ),
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .pcm        ( pcm        ),
        .pcm_en     ( pcm_en     ),
        .rl         ( rl         )
    );

    fm_timers u_timers (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .irq_n      ( irq_n      )
    );

    // Channel 6 PCM is the only sound source
    fm_dac_out u_dac (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .pcm        ( pcm        ),
        .pcm_en     ( pcm_en     ),
        .rl         ( rl         ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

endmodule

/* logic/fm_dac_out.sv */
module fm_dac_out (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     zero,
    input  logic [fm_audio_pkg::PCM_W-1:0]           pcm,
    input  logic                                     pcm_en,
    input  logic [1:0]                               rl,
    output logic signed [fm_audio_pkg::SND_W-1:0]    snd_left,
    output logic signed [fm_audio_pkg::SND_W-1:0]    snd_right,
    output logic                                     snd_sample
);
    import fm_audio_pkg::*;

    logic signed [PCM_W-1:0]    pcm_s;  // Two's complement sample
    logic signed [SND_W-1:0]    pcm_snd;

    // Remove the offset-binary bias
    assign pcm_s = signed'(pcm - PCM_W'(PCM_OFFSET));

    // Sample sits in the top bits, i.e. times 256
    always_comb begin
        pcm_snd = '0;
        if (pcm_en) begin
            pcm_snd = {pcm_s, {(SND_W - PCM_W){1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= zero;  // Aligned with the new output values
            if (zero) begin
                snd_left  <= rl[1] ? pcm_snd : '0;
                snd_right <= rl[0] ? pcm_snd : '0;
            end
        end
    end

    // Samples are many clocks apart
    a_sample_single: assert property (@(posedge clk) disable iff (!rst_n)
        snd_sample |=> !snd_sample);

endmodule

/* logic/fm_mmr.sv */
module fm_mmr (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cen,
    input  logic                                 write,
    input  logic                                 addr_sel,
    input  logic [7:0]                           din,
    output logic                                 busy,
    output logic                                 zero,
    output logic [fm_audio_pkg::TIMER_A_W-1:0]   value_a,
    output logic [fm_audio_pkg::TIMER_B_W-1:0]   value_b,
    output logic                                 load_a,
    output logic                                 load_b,
    output logic                                 irq_en_a,
    output logic                                 irq_en_b,
    output logic                                 clr_flag_a,
    output logic                                 clr_flag_b,
    output logic [fm_audio_pkg::PCM_W-1:0]       pcm,
    output logic                                 pcm_en,
    output logic [1:0]                           rl
);
    import fm_regs_pkg::*;
    import fm_audio_pkg::*;

    logic [7:0]                         reg_sel;   // Latched register number
    logic                               data_wr;
    logic [$clog2(BUSY_CYCLES)-1:0]     busy_cnt;
    logic [$clog2(CEN_DIV)-1:0]         cen_cnt;
    logic [$clog2(NUM_SLOTS)-1:0]       slot;
    logic                               clk_en;

    assign data_wr = write && addr_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_sel    <= '0;
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_en     <= 1'b0;
            rl         <= 2'b11;  // Both sides on
        end else begin
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            if (write && !addr_sel) begin
                reg_sel <= din;
            end
            if (data_wr) begin
                case (reg_sel)
                    REG_TIMER_A_HI: value_a[TIMER_A_W-1:2] <= din;
                    REG_TIMER_A_LO: value_a[1:0] <= din[1:0];
                    REG_TIMER_B:    value_b <= din;
                    REG_TIMER_CTRL: begin
                        load_a     <= din[CTRL_LOAD_A];
                        load_b     <= din[CTRL_LOAD_B];
                        irq_en_a   <= din[CTRL_IRQ_EN_A];
                        irq_en_b   <= din[CTRL_IRQ_EN_B];
                        clr_flag_a <= din[CTRL_CLR_A];  // Pulse, self clearing
                        clr_flag_b <= din[CTRL_CLR_B];
                    end
                    REG_PCM_EN:     pcm_en <= din[7];
                    REG_PAN_CH6:    rl <= din[7:6];
                    default: ;
                endcase
            end
        end
    end

    // PCM sample word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm <= '0;
        end else if (data_wr && reg_sel == REG_PCM_DATA) begin
            pcm <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;  // A write restarts the count
            busy_cnt <= '0;
        end else if (busy && cen) begin
            if (busy_cnt == ($clog2(BUSY_CYCLES))'(BUSY_CYCLES - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    // Internal clock enable and slot counter
    assign clk_en = cen && (cen_cnt == ($clog2(CEN_DIV))'(CEN_DIV - 1));
    assign zero   = clk_en && (slot == ($clog2(NUM_SLOTS))'(NUM_SLOTS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            slot    <= '0;
        end else if (cen) begin
            cen_cnt <= clk_en ? '0 : cen_cnt + 1'b1;
            if (clk_en) begin
                slot <= zero ? '0 : slot + 1'b1;  // Wrap after the last slot
            end
        end
    end

    // Divider and slot counters never leave their range
    a_counters_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (cen_cnt < CEN_DIV) && (slot < NUM_SLOTS));

    // Busy is gone once a full count of cen cycles passes without a write
    a_busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        (data_wr ##1 (cen && !data_wr) [*BUSY_CYCLES + 1]) |-> !busy);

endmodule

/* logic/fm_regs_pkg.sv */
package fm_regs_pkg;

    // Register numbers, part I only
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTRL = 8'h27;
    localparam logic [7:0] REG_PCM_DATA   = 8'h2A;
    localparam logic [7:0] REG_PCM_EN     = 8'h2B;  // Enable in bit 7
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6;  // Left bit 7, right bit 6

    // Bits of register 0x27
    localparam int CTRL_LOAD_A   = 0;
    localparam int CTRL_LOAD_B   = 1;
    localparam int CTRL_IRQ_EN_A = 2;
    localparam int CTRL_IRQ_EN_B = 3;
    localparam int CTRL_CLR_A    = 4;  // Write 1 to clear flag A
    localparam int CTRL_CLR_B    = 5;

    // Status byte layout
    localparam int STAT_FLAG_A = 0;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_BUSY   = 7;

    // Busy time after a data write, in cen cycles
    localparam int BUSY_CYCLES = 32;

endpackage

/* logic/fm_timers.sv */
module fm_timers (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 zero,
    input  logic [fm_audio_pkg::TIMER_A_W-1:0]   value_a,
    input  logic [fm_audio_pkg::TIMER_B_W-1:0]   value_b,
    input  logic                                 load_a,
    input  logic                                 load_b,
    input  logic                                 irq_en_a,
    input  logic                                 irq_en_b,
    input  logic                                 clr_flag_a,
    input  logic                                 clr_flag_b,
    output logic                                 flag_a,
    output logic                                 flag_b,
    output logic                                 irq_n
);
    import fm_audio_pkg::*;

    logic [TIMER_A_W-1:0]                   cnt_a;
    logic [TIMER_B_W-1:0]                   cnt_b;
    logic [$clog2(TIMER_B_PRESCALE)-1:0]    presc_b;
    logic                                   load_a_d;
    logic                                   load_b_d;
    logic                                   start_a;
    logic                                   start_b;
    logic                                   step_b;
    logic                                   ovf_a;
    logic                                   ovf_b;

    // Counting begins on the rising edge of the load bit
    assign start_a = load_a && !load_a_d;
    assign start_b = load_b && !load_b_d;

    assign step_b = zero && (presc_b == ($clog2(TIMER_B_PRESCALE))'(TIMER_B_PRESCALE - 1));
    assign ovf_a  = load_a && !start_a && zero && (&cnt_a);
    assign ovf_b  = load_b && !start_b && step_b && (&cnt_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_a_d <= 1'b0;
            load_b_d <= 1'b0;
            cnt_a    <= '0;
            cnt_b    <= '0;
            presc_b  <= '0;
        end else begin
            load_a_d <= load_a;
            load_b_d <= load_b;
            if (start_a) begin
                cnt_a <= value_a;
            end else if (load_a && zero) begin
                cnt_a <= ovf_a ? value_a : cnt_a + 1'b1;  // Reload on wrap
            end
            if (start_b) begin
                cnt_b   <= value_b;
                presc_b <= '0;
            end else if (load_b && zero) begin
                presc_b <= presc_b + 1'b1;
                if (step_b) begin
                    cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
                end
            end
        end
    end

    // Setting wins over a clear in the same clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && irq_en_a) flag_a <= 1'b1;
            else if (clr_flag_a)   flag_a <= 1'b0;
            if (ovf_b && irq_en_b) flag_b <= 1'b1;
            else if (clr_flag_b)   flag_b <= 1'b0;
        end
    end

    assign irq_n = !(flag_a || flag_b);

    a_flag_on_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(flag_a) || $rose(flag_b)) |-> $past(zero));

endmodule

/* project.f */
logic/fm_regs_pkg.sv
logic/fm_audio_pkg.sv
logic/fm_mmr.sv
logic/fm_timers.sv
logic/fm_dac_out.sv
logic/fm_chip_top.sv
testbench/tb_fm_chip.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FM chip testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_fm_chip -f project.f -o sim_fm_chip
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fm_chip > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* testbench/tb_fm_chip.sv */
module tb_fm_chip;
    timeunit 1ns;
    timeprecision 100ps;

    import fm_regs_pkg::*;
    import fm_audio_pkg::*;

    localparam int BUSY_TIMEOUT   = 40;   // Clocks, busy lasts 32
    localparam int SAMPLE_TIMEOUT = 200;  // One sample is 144 clocks

    logic                      clk;
    logic                      rst_n;
    logic                      cen;
    logic [7:0]                din;
    logic [1:0]                addr;
    logic                      cs_n;
    logic                      wr_n;
    logic [7:0]                dout;
    logic                      irq_n;
    logic signed [SND_W-1:0]   snd_left;
    logic signed [SND_W-1:0]   snd_right;
    logic                      snd_sample;

    logic [31:0]               lfsr_state = 32'h0b72_d72c;
    string                     test_name;
    logic [PCM_W-1:0]          exp_pcm;    // Model of the DAC inputs
    logic                      exp_en;
    logic [1:0]                exp_rl;
    int                        requested;
    int                        checked;

    fm_chip_top i_dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[6:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Offset-binary PCM to signed, times 256, gated by enable and pan side
    function automatic logic signed [SND_W-1:0] ref_sound(input logic [PCM_W-1:0] sample,
                                                          input logic en, input logic side_on);
        int level;
        level = 0;
        if (en && side_on) level = (int'(sample) - PCM_OFFSET) * 256;
        return SND_W'(level);
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_sound(input string name, input logic signed [SND_W-1:0] expected,
                               input logic signed [SND_W-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped");
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped");
        end
    endtask

    // Accepts expected up to expected + slack
    task automatic check_count(input string name, input int expected, input int actual,
                               input int slack);
        if (actual < expected || actual > expected + slack) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped");
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (dout[STAT_BUSY] !== 1'b0) begin
            if (n >= BUSY_TIMEOUT) report_timeout("busy to clear");
            @(negedge clk);
            n = n + 1;
        end
    endtask

    task automatic write_reg(input logic [7:0] reg_num, input logic [7:0] data);
        wait_not_busy();
        @(negedge clk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;  // Address port
        din  = reg_num;
        @(negedge clk);
        addr = 2'b01;  // Data port
        din  = data;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'b00;
        din  = '0;
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        @(negedge clk);
        while (snd_sample !== 1'b1) begin
            if (n >= SAMPLE_TIMEOUT) report_timeout("a sample strobe");
            @(negedge clk);
            n = n + 1;
        end
    endtask

    // Clocks from one sample strobe to the next
    task automatic measure_sample_period(output int period);
        int n;
        wait_sample();
        n = 0;
        do begin
            @(negedge clk);
            n = n + 1;
            if (n > SAMPLE_TIMEOUT) report_timeout("the next sample strobe");
        end while (snd_sample !== 1'b1);
        period = n;
    endtask

    task automatic count_samples_to_irq(input int limit, output int count);
        int  n;
        logic done;
        n     = 0;
        count = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (snd_sample) count = count + 1;
            if (!irq_n) begin
                done = 1'b1;
            end else begin
                n = n + 1;
                if (n > limit) report_timeout("irq_n to fall");
            end
        end
    endtask

    task automatic wait_compare(input int target);
        int n;
        n = 0;
        while (checked != target) begin
            if (n >= SAMPLE_TIMEOUT) report_timeout("the sound compare");
            @(posedge clk);
            n = n + 1;
        end
    endtask

    task automatic apply_sound(input logic [7:0] sample, input logic [1:0] pan,
                               input logic en);
        write_reg(REG_PCM_DATA, sample);
        write_reg(REG_PAN_CH6, {pan, 6'b0});
        exp_pcm = sample;
        exp_en  = en;
        exp_rl  = pan;
        wait_sample();  // Skipped
        requested <= requested + 1;
        wait_compare(requested + 1);
    endtask

    // Compares at each requested sample strobe
    always @(negedge clk) begin
        if (snd_sample && checked != requested) begin
            check_sound({test_name, " left"}, ref_sound(exp_pcm, exp_en, exp_rl[1]), snd_left);
            check_sound({test_name, " right"}, ref_sound(exp_pcm, exp_en, exp_rl[0]), snd_right);
            checked <= checked + 1;
        end
    end

    initial begin
        int         count;
        logic [7:0] sample;
        logic [7:0] pan;
        rst_n     = 1'b0;
        cen       = 1'b1;
        din       = '0;
        addr      = 2'b00;
        cs_n      = 1'b1;
        wr_n      = 1'b1;
        requested = 0;
        checked   = 0;
        exp_pcm   = '0;
        exp_en    = 1'b0;
        exp_rl    = 2'b11;
        test_name = "reset";
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check_status("reset dout", 8'h00, dout);
        check_count("reset irq_n", 1, int'(irq_n), 0);
        check_count("reset snd_sample", 0, int'(snd_sample), 0);
        check_sound("reset left", '0, snd_left);
        check_sound("reset right", '0, snd_right);

        // Six enables per slot, 24 slots per sample
        test_name = "sample_period";
        measure_sample_period(count);
        check_count("sample period", CEN_DIV * NUM_SLOTS, count, 0);

        test_name = "busy";
        write_reg(REG_PCM_DATA, 8'h80);
        check_status("busy set", 8'h80, dout);
        wait_not_busy();
        check_status("busy clear", 8'h00, dout);

        // Timer A 1020, four samples to overflow
        test_name = "timer_a";
        write_reg(REG_TIMER_A_HI, 8'd255);
        write_reg(REG_TIMER_A_LO, 8'd0);
        write_reg(REG_TIMER_CTRL, 8'h05);
        count_samples_to_irq(8 * 144, count);
        check_count("timer_a samples", 4, count, 1);
        check_status("timer_a status", 8'h01, dout);
        write_reg(REG_TIMER_CTRL, 8'h10);
        wait_not_busy();
        check_count("timer_a irq_n cleared", 1, int'(irq_n), 0);
        check_status("timer_a status cleared", 8'h00, dout);

        // Timer B 254, prescaled by 16
        test_name = "timer_b";
        write_reg(REG_TIMER_B, 8'd254);
        write_reg(REG_TIMER_CTRL, 8'h0A);
        count_samples_to_irq(36 * 144, count);
        check_count("timer_b samples", 32, count, 1);
        check_status("timer_b status", 8'h02, dout);
        write_reg(REG_TIMER_CTRL, 8'h20);
        wait_not_busy();
        check_count("timer_b irq_n cleared", 1, int'(irq_n), 0);

        test_name = "pcm_pan";
        write_reg(REG_PCM_EN, 8'h80);
        for (int i = 0; i < 20; i++) begin
            sample = take_bits(8);
            pan    = take_bits(2);
            apply_sound(sample, pan[1:0], 1'b1);
        end

        test_name = "pcm_disabled";
        write_reg(REG_PCM_EN, 8'h00);
        for (int i = 0; i < 3; i++) begin
            sample = take_bits(8);
            pan    = take_bits(2);
            apply_sound(sample, pan[1:0], 1'b0);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
